// ==== design/cpu_params.svh ====
// CPU core parameters
// reset vector, data bank and register count for the 16-bit core

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first fetch address after reset
`define CPU_PC_RSTVAL 24'h000100

// upper address byte for LD, ST and STB accesses
`define CPU_DATA_BANK 8'h01

// WA, BC, DE, HL, IX, IY, IZ, SP
`define CPU_NREGS 8

`endif

// ==== design/cpu_pkg.sv ====
// CPU core package
// data types, opcodes, ALU operations and bus structs of the 16-bit core

`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [23:0] addr_t;
    // 0 WA, 1 BC, 2 DE, 3 HL, 4 IX, 5 IY, 6 IZ, 7 SP
    typedef logic [2:0]  reg_sel_t;

    // codes 8 to 15 run as NOP
    typedef enum logic [3:0] {
        NOP = 4'd0, LDI = 4'd1, ALU = 4'd2, LD   = 4'd3,
        ST  = 4'd4, STB = 4'd5, JR  = 4'd6, HALT = 4'd7
    } opcode_e;

    // taken from low[2:0] of an ALU instruction, 6 and 7 add
    typedef enum logic [2:0] {
        ADD = 3'd0, SUB = 3'd1, AND = 3'd2, OR = 3'd3, XOR = 3'd4, CP = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        COND_ALWAYS = 2'd0, COND_Z = 2'd1, COND_NZ = 2'd2, COND_C = 2'd3
    } cond_e;

    typedef struct packed {
        opcode_e    op;
        reg_sel_t   dst;
        reg_sel_t   src;
        logic [5:0] low;
    } instr_t;

    typedef struct packed {
        logic s;
        logic z;
        logic v;
        logic c;
    } flags_t;

    typedef enum logic [1:0] {FETCH, EXEC, MEM, HALTED} ctrl_state_e;

    typedef struct packed {
        logic     we;
        reg_sel_t sel;
        word_t    data;
    } reg_wr_t;

endpackage

`default_nettype wire

// ==== design/cpu_ctrl.sv ====
// CPU controller
// fetch/execute FSM with program counter, instruction register,
// decode, jump condition and register write-back selection

`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_ctrl (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   cen,
    input  wire cpu_pkg::word_t   din,
    input  wire cpu_pkg::word_t   alu_dout,
    input  wire cpu_pkg::flags_t  flags,
    output cpu_pkg::addr_t        pc,
    output cpu_pkg::ctrl_state_e  state,
    output cpu_pkg::opcode_e      op_kind,
    output cpu_pkg::alu_op_e      alu_op,
    output logic                  flag_we,
    output cpu_pkg::reg_sel_t     rd_sel_a,
    output cpu_pkg::reg_sel_t     rd_sel_b,
    output cpu_pkg::reg_wr_t      reg_wr,
    output logic                  halted
);

    cpu_pkg::instr_t  ir;
    cpu_pkg::word_t   ir_word;
    cpu_pkg::cond_e   cond;
    logic [7:0]       disp;
    logic             taken;
    cpu_pkg::addr_t   jr_target;

    // decode
    assign ir_word  = ir;
    assign op_kind  = ir.op;
    assign alu_op   = cpu_pkg::alu_op_e'(ir.low[2:0]);
    assign rd_sel_a = ir.dst;
    assign rd_sel_b = ir.src;
    assign cond     = cpu_pkg::cond_e'(ir.dst[1:0]);
    assign disp     = ir_word[7:0];
    assign flag_we  = (state == cpu_pkg::EXEC) && (ir.op == cpu_pkg::ALU);
    assign halted   = (state == cpu_pkg::HALTED);

    // displacement counts words, pc already points past the JR
    assign jr_target = pc + {{15{disp[7]}}, disp, 1'b0};

    always_comb begin
        case (cond)
            cpu_pkg::COND_Z:  taken = flags.z;
            cpu_pkg::COND_NZ: taken = !flags.z;
            cpu_pkg::COND_C:  taken = flags.c;
            default:          taken = 1'b1;
        endcase
    end

    // write-back source: immediate, ALU result or load data
    always_comb begin
        reg_wr      = '0;
        reg_wr.sel  = ir.dst;
        reg_wr.data = alu_dout;
        if (state == cpu_pkg::EXEC) begin
            if (ir.op == cpu_pkg::LDI) begin
                reg_wr.we   = 1'b1;
                reg_wr.data = {8'h00, ir_word[7:0]};
            end else if (ir.op == cpu_pkg::ALU) begin
                // compare only touches the flags
                reg_wr.we = (alu_op != cpu_pkg::CP);
            end
        end else if (state == cpu_pkg::MEM && ir.op == cpu_pkg::LD) begin
            reg_wr.we   = 1'b1;
            reg_wr.data = din;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && state == cpu_pkg::FETCH) begin
            ir <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::FETCH;
            pc    <= `CPU_PC_RSTVAL;
        end else if (cen) begin
            case (state)
                cpu_pkg::FETCH: begin
                    pc    <= pc + 24'd2;
                    state <= cpu_pkg::EXEC;
                end
                cpu_pkg::EXEC: begin
                    case (ir.op)
                        cpu_pkg::LD, cpu_pkg::ST, cpu_pkg::STB: state <= cpu_pkg::MEM;
                        cpu_pkg::HALT: state <= cpu_pkg::HALTED;
                        cpu_pkg::JR: begin
                            if (taken) begin
                                pc <= jr_target;
                            end
                            state <= cpu_pkg::FETCH;
                        end
                        default: state <= cpu_pkg::FETCH;
                    endcase
                end
                cpu_pkg::MEM: state <= cpu_pkg::FETCH;
                default:      state <= cpu_pkg::HALTED;
            endcase
        end
    end

    // only reset leaves the halted state
    halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted fell without reset");

endmodule

`default_nettype wire

// ==== design/cpu_regs.sv ====
// CPU register bank
// eight 16-bit registers, two read ports, one write port
// and a byte-wide dump port for inspection

`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_regs (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cen,
    input  wire cpu_pkg::reg_sel_t  rd_sel_a,
    input  wire cpu_pkg::reg_sel_t  rd_sel_b,
    input  wire cpu_pkg::reg_wr_t   reg_wr,
    input  wire [3:0]               dmp_addr,
    output cpu_pkg::word_t          rd_a,
    output cpu_pkg::word_t          rd_b,
    output logic [7:0]              dmp_dout
);

    cpu_pkg::word_t [`CPU_NREGS-1:0] regs;
    cpu_pkg::word_t                  dmp_word;

    assign rd_a = regs[rd_sel_a];
    assign rd_b = regs[rd_sel_b];

    // register in bits 3..1, bit 0 picks the high byte
    assign dmp_word = regs[dmp_addr[3:1]];
    assign dmp_dout = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (cen && reg_wr.we) begin
            regs[reg_wr.sel] <= reg_wr.data;
        end
    end

    // register contents hold while the clock enable is low
    regs_hold: assert property (@(posedge clk) !reset && !cen |=> $stable(regs))
        else $error("register bank changed with cen low");

endmodule

`default_nettype wire

// ==== design/cpu_alu.sv ====
// CPU ALU
// combinational add, subtract, logic and compare on 16 bits
// with a flags register loaded on request from the controller

`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    cen,
    input  wire cpu_pkg::alu_op_e  op,
    input  wire cpu_pkg::word_t    a,
    input  wire cpu_pkg::word_t    b,
    input  wire                    flag_we,
    output cpu_pkg::word_t         dout,
    output cpu_pkg::flags_t        flags
);

    logic [16:0]      sum;
    cpu_pkg::word_t   res;
    logic             carry;
    logic             ovf;
    cpu_pkg::flags_t  nx_flags;

    always_comb begin
        sum   = '0;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            cpu_pkg::SUB, cpu_pkg::CP: begin
                // bit 16 is the borrow
                sum   = {1'b0, a} - {1'b0, b};
                res   = sum[15:0];
                carry = sum[16];
                ovf   = (a[15] != b[15]) && (res[15] != a[15]);
            end
            cpu_pkg::AND: res = a & b;
            cpu_pkg::OR:  res = a | b;
            cpu_pkg::XOR: res = a ^ b;
            default: begin
                sum   = {1'b0, a} + {1'b0, b};
                res   = sum[15:0];
                carry = sum[16];
                ovf   = (a[15] == b[15]) && (res[15] != a[15]);
            end
        endcase
    end

    assign dout = res;

    always_comb begin
        nx_flags.s = res[15];
        nx_flags.z = (res == 16'h0000);
        nx_flags.v = ovf;
        nx_flags.c = carry;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (cen && flag_we) begin
            flags <= nx_flags;
        end
    end

    flag_we_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(flag_we))
        else $error("flag_we unknown");

endmodule

`default_nettype wire

// ==== design/cpu_ramctl.sv ====
// CPU memory controller
// picks the fetch or data address and steers store data onto the byte lanes

`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_ramctl (
    input  wire                        cen,
    input  wire cpu_pkg::ctrl_state_e  state,
    input  wire cpu_pkg::opcode_e      op_kind,
    input  wire cpu_pkg::addr_t        pc,
    input  wire cpu_pkg::word_t        rd_a,
    input  wire cpu_pkg::word_t        rd_b,
    output cpu_pkg::addr_t             addr,
    output cpu_pkg::word_t             dout,
    output logic [1:0]                 we
);

    logic data_cycle;
    logic st_word;
    logic st_byte;

    assign data_cycle = (state == cpu_pkg::MEM);
    assign st_word    = data_cycle && (op_kind == cpu_pkg::ST);
    assign st_byte    = data_cycle && (op_kind == cpu_pkg::STB);

    // src register addresses data inside the fixed bank
    assign addr = data_cycle ? {`CPU_DATA_BANK, rd_b} : pc;

    // byte stores repeat the low byte on both lanes
    assign dout = st_byte ? {2{rd_a[7:0]}} : rd_a;

    always_comb begin
        we = 2'b00;
        if (cen) begin
            if (st_word) begin
                we = 2'b11;
            end else if (st_byte) begin
                we = addr[0] ? 2'b10 : 2'b01;
            end
        end
    end

    always_comb begin
        byte_lane: assert (!(st_byte && we == 2'b11))
            else $error("byte store drove both lanes");
    end

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
// 16-bit CPU core top level
// controller, register bank, ALU and memory controller on a
// 24-bit address / 16-bit data bus with a register dump port

`timescale 1ns/10ps
`default_nettype none

module cpu_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   cen,
    input  wire cpu_pkg::word_t   din,
    input  wire [3:0]             dmp_addr,
    output cpu_pkg::addr_t        addr,
    output cpu_pkg::word_t        dout,
    output logic [1:0]            we,
    output logic                  halted,
    output logic [7:0]            dmp_dout
);

    cpu_pkg::addr_t        pc;
    cpu_pkg::ctrl_state_e  state;
    cpu_pkg::opcode_e      op_kind;
    cpu_pkg::alu_op_e      alu_op;
    logic                  flag_we;
    cpu_pkg::reg_sel_t     rd_sel_a, rd_sel_b;
    cpu_pkg::reg_wr_t      reg_wr;
    cpu_pkg::word_t        rd_a, rd_b, alu_dout;
    cpu_pkg::flags_t       flags;

    cpu_ctrl u_ctrl (
        .clk      ( clk      ), .reset    ( reset    ), .cen      ( cen      ),
        .din      ( din      ), .alu_dout ( alu_dout ), .flags    ( flags    ),
        .pc       ( pc       ), .state    ( state    ), .op_kind  ( op_kind  ),
        .alu_op   ( alu_op   ), .flag_we  ( flag_we  ), .rd_sel_a ( rd_sel_a ),
        .rd_sel_b ( rd_sel_b ), .reg_wr   ( reg_wr   ), .halted   ( halted   )
    );

    cpu_regs u_regs (
        .clk      ( clk      ), .reset    ( reset    ), .cen      ( cen      ),
        .rd_sel_a ( rd_sel_a ), .rd_sel_b ( rd_sel_b ), .reg_wr   ( reg_wr   ),
        .dmp_addr ( dmp_addr ), .rd_a     ( rd_a     ), .rd_b     ( rd_b     ),
        .dmp_dout ( dmp_dout )
    );

    cpu_alu u_alu (
        .clk   ( clk   ), .reset   ( reset   ), .cen  ( cen      ),
        .op    ( alu_op), .a       ( rd_a    ), .b    ( rd_b     ),
        .flag_we ( flag_we ), .dout ( alu_dout ), .flags ( flags )
    );

    cpu_ramctl u_ramctl (
        .cen   ( cen   ), .state ( state ), .op_kind ( op_kind ),
        .pc    ( pc    ), .rd_a  ( rd_a  ), .rd_b    ( rd_b    ),
        .addr  ( addr  ), .dout  ( dout  ), .we      ( we      )
    );

endmodule

`default_nettype wire

// ==== verification/cpu_tb.sv ====
// CPU core testbench
// runs random programs on the core and on a reference model
// and compares every bus store and the final register dump

`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;

    localparam int NINSTR  = 200;
    localparam int TIMEOUT = 20000;
    localparam int BASE    = int'(`CPU_PC_RSTVAL);

    typedef struct packed {
        cpu_pkg::addr_t a;
        cpu_pkg::word_t d;
        logic [1:0]     w;
    } store_t;

    logic           clk = 1'b0;
    logic           reset = 1'b1;
    logic           cen = 1'b0;
    logic [3:0]     dmp_addr = 4'h0;
    logic           load = 1'b0;
    cpu_pkg::word_t din;
    cpu_pkg::addr_t addr;
    cpu_pkg::word_t dout;
    logic [1:0]     we;
    logic           halted;
    logic [7:0]     dmp_dout;

    logic [7:0]     mem [0:65535];
    logic [7:0]     img [0:1023];
    logic [7:0]     mmem [0:1023];
    cpu_pkg::word_t mregs [0:7];
    store_t         exp_q [$];
    logic           halted_seen;
    int             errors = 0;
    int             checks = 0;

    cpu_top DUT (
        .clk(clk), .reset(reset), .cen(cen), .din(din), .dmp_addr(dmp_addr),
        .addr(addr), .dout(dout), .we(we), .halted(halted), .dmp_dout(dmp_dout)
    );

    always #50 clk = ~clk;

    // word-organized memory where addr bit 0 only picks the lane
    assign din = {mem[{addr[15:1], 1'b1}], mem[{addr[15:1], 1'b0}]};

    always @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < 1024; i++) begin
                mem[16'(i)] <= img[10'(i)];
            end
        end else begin
            if (we[0]) mem[{addr[15:1], 1'b0}] <= dout[7:0];
            if (we[1]) mem[{addr[15:1], 1'b1}] <= dout[15:8];
        end
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic next_cen(input logic rand_cen);
        // enabled about three cycles in four
        return rand_cen ? ($urandom_range(3, 0) != 0) : 1'b1;
    endfunction

    task automatic gen_program();
        logic [15:0] w;
        int unsigned kind;
        for (int i = 0; i < 1024; i++) begin
            img[10'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        for (int i = 0; i < NINSTR + 4; i++) begin
            w    = 16'($urandom);
            kind = $urandom_range(15, 0);
            if (i >= NINSTR) begin
                // trailing halts also catch jumps past the last instruction
                w = 16'h7000;
            end else begin
                // ALU and LD write only WA..HL so IX..SP keep LDI byte addresses
                case (kind)
                    0:          w[15:12] = 4'h0;
                    1:          w[15] = 1'b1;
                    2, 3, 4:    w[15:12] = 4'h1;
                    5, 6, 7, 8: w[15:11] = {4'h2, 1'b0};
                    9:          w[15:11] = {4'h3, 1'b0};
                    10:         w[15:12] = 4'h4;
                    11:         w[15:12] = 4'h5;
                    default:    w[15:12] = 4'h6;
                endcase
                if (kind >= 9 && kind <= 11) w[8] = 1'b1;
                if (kind >= 12) w[7:0] = 8'($urandom_range(3, 0));
            end
            img[10'(BASE + 2 * i)]     = w[7:0];
            img[10'(BASE + 2 * i + 1)] = w[15:8];
        end
    endtask

    task automatic run_model();
        cpu_pkg::addr_t  pc;
        cpu_pkg::instr_t ins;
        cpu_pkg::word_t  a;
        cpu_pkg::word_t  b;
        logic [16:0]     res;
        logic [7:0]      imm;
        logic            zf;
        logic            cf;
        logic            taken;
        logic            done;
        store_t          st;
        for (int i = 0; i < 1024; i++) begin
            mmem[10'(i)] = img[10'(i)];
        end
        for (int i = 0; i < 8; i++) begin
            mregs[3'(i)] = '0;
        end
        exp_q.delete();
        zf   = 1'b0;
        cf   = 1'b0;
        pc   = `CPU_PC_RSTVAL;
        done = 1'b0;
        while (!done) begin
            ins  = {mmem[pc[9:0] + 10'd1], mmem[pc[9:0]]};
            pc   = pc + 24'd2;
            a    = mregs[ins.dst];
            b    = mregs[ins.src];
            imm  = {ins.src[1:0], ins.low};
            st.a = {`CPU_DATA_BANK, b};
            st.d = a;
            st.w = 2'b11;
            case (ins.op)
                cpu_pkg::LDI: mregs[ins.dst] = {8'h00, imm};
                cpu_pkg::ALU: begin
                    case (ins.low[2:0])
                        3'd1, 3'd5: res = {1'b0, a} - {1'b0, b};
                        3'd2:       res = {1'b0, a & b};
                        3'd3:       res = {1'b0, a | b};
                        3'd4:       res = {1'b0, a ^ b};
                        default:    res = {1'b0, a} + {1'b0, b};
                    endcase
                    zf = (res[15:0] == 16'h0000);
                    cf = res[16];
                    if (ins.low[2:0] != 3'd5) mregs[ins.dst] = res[15:0];
                end
                cpu_pkg::LD: mregs[ins.dst] = {mmem[{b[9:1], 1'b1}], mmem[{b[9:1], 1'b0}]};
                cpu_pkg::ST: begin
                    mmem[{b[9:1], 1'b0}] = a[7:0];
                    mmem[{b[9:1], 1'b1}] = a[15:8];
                    exp_q.push_back(st);
                end
                cpu_pkg::STB: begin
                    st.d = {a[7:0], a[7:0]};
                    st.w = b[0] ? 2'b10 : 2'b01;
                    mmem[b[9:0]] = a[7:0];
                    exp_q.push_back(st);
                end
                cpu_pkg::JR: begin
                    case (ins.dst[1:0])
                        2'd1:    taken = zf;
                        2'd2:    taken = !zf;
                        2'd3:    taken = cf;
                        default: taken = 1'b1;
                    endcase
                    // displacement in words from the next instruction
                    if (taken) pc = pc + {{15{imm[7]}}, imm, 1'b0};
                end
                cpu_pkg::HALT: done = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic watch_bus();
        store_t st;
        if (!cen && we != 2'b00) begin
            errors++;
            $display("write strobe active while cen is low");
        end
        if (halted_seen && !halted) begin
            errors++;
            $display("halted fell without a reset");
        end
        if (halted) halted_seen = 1'b1;
        if (we != 2'b00) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("store to %h that the model does not expect", addr);
            end else begin
                st = exp_q.pop_front();
                expect_eq("addr", 32'(addr), 32'(st.a));
                expect_eq("dout", 32'(dout), 32'(st.d));
                expect_eq("we", 32'(we), 32'(st.w));
            end
        end
    endtask

    task automatic exercise_dut(input logic rand_cen, output logic ok);
        int         cycles;
        logic [7:0] exp_byte;
        ok          = 1'b1;
        halted_seen = 1'b0;
        @(posedge clk);
        reset <= 1'b1;
        load  <= 1'b1;
        cen   <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        load  <= 1'b0;
        cen   <= next_cen(rand_cen);
        @(negedge clk);
        expect_eq("addr", 32'(addr), 32'(`CPU_PC_RSTVAL));
        expect_eq("we", 32'(we), 32'h0);
        expect_eq("halted", 32'(halted), 32'h0);
        watch_bus();
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(posedge clk);
            cen <= next_cen(rand_cen);
            @(negedge clk);
            watch_bus();
            cycles++;
        end
        if (!halted) begin
            errors++;
            ok = 1'b0;
            $display("timeout, halted not raised within %0d cycles", TIMEOUT);
        end else begin
            for (int i = 0; i < 16; i++) begin
                @(posedge clk);
                dmp_addr <= 4'(i);
                cen      <= next_cen(rand_cen);
                @(negedge clk);
                watch_bus();
                exp_byte = i[0] ? mregs[3'(i / 2)][15:8] : mregs[3'(i / 2)][7:0];
                expect_eq("dmp_dout", 32'(dmp_dout), 32'(exp_byte));
            end
            expect_eq("pending stores", 32'(exp_q.size()), 32'h0);
        end
    endtask

    initial begin
        logic ok;
        void'($urandom(32'h51f2_07d3));
        gen_program();
        run_model();
        exercise_dut(1'b1, ok);
        // same program again with cen held high
        if (ok) begin
            run_model();
            exercise_dut(1'b0, ok);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (ok && errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/cpu_pkg.sv
design/cpu_ctrl.sv
design/cpu_regs.sv
design/cpu_alu.sv
design/cpu_ramctl.sv
design/cpu_top.sv
verification/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the CPU testbench with Verilator, run it and judge the log
rm -f sim.log &&
verilator --binary --timing --assert -f src.f --top-module cpu_tb -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim | tee sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
